/* bench/tb_slm_panel.sv */
/*
 * testbench for the front-panel control top level
 * xorshift stimulus, trace and offset model, typed compare tasks
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module tb_slm_panel;

    localparam int MAX_CYCLES = 2000;
    // active low, gfedcba order
    localparam panel_pkg::seg_t SEG_OFF = 7'b1111111;
    localparam panel_pkg::hex_bank_t HEX_BUSY = '{hex5: 7'b0000011, hex4: 7'b1000001,
        hex3: 7'b0010010, hex2: 7'b0010001, hex1: SEG_OFF, hex0: SEG_OFF};
    localparam panel_pkg::hex_bank_t HEX_BLANK = '1;

    logic                 CLOCK_50;
    logic                 delayed_reset;
    panel_pkg::keys_t     keys;
    panel_pkg::switches_t switches;
    trace_pkg::probe_t    probe;
    logic                 write_done;
    panel_pkg::offset_t   x_offset;
    panel_pkg::offset_t   y_offset;
    trace_pkg::leds_t     leds;
    panel_pkg::hex_bank_t hex;

    logic [31:0] rng;
    int          cycles;
    // trace model, index 0 oldest
    trace_pkg::sample_t hist_m [`SLM_TRACE_PRE];
    trace_pkg::sample_t slots_m [`SLM_TRACE_SLOTS];
    int                 post_m;

    slm_panel_top dut0 (.*);

    always #10 CLOCK_50 = ~CLOCK_50;

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic panel_pkg::offset_t offset_from(input panel_pkg::switches_t sw);
        panel_pkg::offset_t o;
        o.sign = sw[9];
        o.mag  = sw[`SLM_MAG_W-1:0];
        return o;
    endfunction

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // one edge of the trace rules, using the probe the DUT sees now
    task automatic trace_model_step();
        trace_pkg::sample_t cur;
        cur = probe[`SLM_SAMPLE_W-1:0];
        if (probe[`SLM_STROBE_BIT]) begin
            for (int i = 0; i < `SLM_TRACE_PRE; i++) slots_m[i] = hist_m[i];
            slots_m[`SLM_TRACE_PRE] = cur;
            post_m = 1;
        end else if (post_m != 0) begin
            slots_m[`SLM_TRACE_PRE + post_m] = cur;
            post_m = (post_m == `SLM_TRACE_POST) ? 0 : post_m + 1;
        end
        for (int i = 0; i < `SLM_TRACE_PRE - 1; i++) hist_m[i] = hist_m[i+1];
        hist_m[`SLM_TRACE_PRE-1] = cur;
    endtask

    // advance one clock, inputs change 2 ns after the edge
    task automatic ticks(input int n);
        repeat (n) begin
            trace_model_step();
            @(posedge CLOCK_50);
            #2;
        end
    endtask

    task automatic press_key(input int k, input int hold);
        keys[k] = 1'b0;
        ticks(hold);
        keys[k] = 1'b1;
    endtask

    task automatic check_offset(input string what, input panel_pkg::offset_t got,
                                input panel_pkg::offset_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got sign %0b mag %0d, expected sign %0b mag %0d",
                     $time, what, got.sign, got.mag, exp.sign, exp.mag);
            stop_with_failure();
        end
    endtask

    task automatic check_leds(input string what, input trace_pkg::leds_t got,
                              input trace_pkg::leds_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_hex(input string what, input panel_pkg::hex_bank_t got,
                             input panel_pkg::hex_bank_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // run limit, well above the length of all tests
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        panel_pkg::switches_t sw_a;
        panel_pkg::switches_t sw_b;
        CLOCK_50      = 1'b0;
        delayed_reset = 1'b1;
        keys          = '1;
        switches      = '0;
        probe         = '0;
        write_done    = 1'b0;
        rng           = 32'hfa9e_66e7;
        cycles        = 0;
        post_m        = 0;
        for (int i = 0; i < `SLM_TRACE_PRE; i++) hist_m[i] = '0;
        for (int i = 0; i < `SLM_TRACE_SLOTS; i++) slots_m[i] = '0;
        repeat (8) @(posedge CLOCK_50);
        #2;
        delayed_reset = 1'b0;

        // reset defaults
        check_offset("x after reset", x_offset, '{sign: 1'b1, mag: 8'd127});
        check_offset("y after reset", y_offset, '{sign: 1'b0, mag: 8'd3});

        // key 3 loads x only
        rng = xorshift(rng);
        sw_a = rng[9:0];
        switches = sw_a;
        press_key(3, 2);
        ticks(`SLM_KEY_DELAY_CYCLES + 3);
        check_offset("x after key 3", x_offset, offset_from(sw_a));
        check_offset("y after key 3", y_offset, '{sign: 1'b0, mag: 8'd3});

        // key 2 loads y, second press inside the delay is dropped
        rng = xorshift(rng);
        sw_b = rng[9:0];
        switches = sw_b;
        press_key(2, 2);
        ticks(3);
        press_key(2, 2);
        ticks(`SLM_KEY_DELAY_CYCLES);
        check_offset("y after key 2", y_offset, offset_from(sw_b));
        check_offset("x after key 2", x_offset, offset_from(sw_a));
        switches = ~sw_b;
        ticks(`SLM_KEY_DELAY_CYCLES + 6);
        check_offset("y after ignored press", y_offset, offset_from(sw_b));

        // trace windows, occasional early strobes restart the window
        for (int r = 0; r < 3; r++) begin
            switches = '0;
            for (int i = 0; i < 12 + 3 * r; i++) begin
                rng = xorshift(rng);
                probe = rng[18:0];
                if (rng[31:29] != 3'd0) probe[`SLM_STROBE_BIT] = 1'b0;
                ticks(1);
            end
            rng = xorshift(rng);
            probe = rng[18:0];
            probe[`SLM_STROBE_BIT] = 1'b1;
            ticks(1);
            for (int i = 0; i < `SLM_TRACE_POST + 1; i++) begin
                rng = xorshift(rng);
                probe = rng[18:0];
                probe[`SLM_STROBE_BIT] = 1'b0;
                ticks(1);
            end
            probe = '0;
            for (int s = 0; s < `SLM_TRACE_SLOTS; s++) begin
                switches = panel_pkg::switches_t'(s);
                ticks(1);
                check_leds("slot readout", leds, {1'b0, slots_m[s]});
            end
        end

        // upper switches select the probe status field
        for (int i = 0; i < 20; i++) begin
            rng = xorshift(rng);
            switches = rng[9:0];
            if (switches[`SLM_SW_W-1:4] == '0) switches[4] = 1'b1;
            probe = rng[28:10];
            ticks(1);
            check_leds("probe status", leds, probe[`SLM_PROBE_W-1:`SLM_SAMPLE_W]);
        end

        // busy message until write_done
        write_done = 1'b0;
        ticks(1);
        check_hex("digits while busy", hex, HEX_BUSY);
        write_done = 1'b1;
        ticks(1);
        check_hex("digits when done", hex, HEX_BLANK);

        if (dut0.u_props.failures != 0) begin
            $display("concurrent assertions failed %0d times", dut0.u_props.failures);
            stop_with_failure();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* bench/tb_slm_panel_properties.sv */
/*
 * concurrent checks on the front-panel top level
 * bound into slm_panel_top, counts its own assertion failures
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module tb_slm_panel_properties (
    input logic                 CLOCK_50,
    input logic                 delayed_reset,
    input panel_pkg::keys_t     keys,
    input panel_pkg::switches_t switches,
    input trace_pkg::probe_t    probe,
    input panel_pkg::offset_t   x_offset,
    input panel_pkg::offset_t   y_offset,
    input trace_pkg::leds_t     leds,
    input panel_pkg::hex_bank_t hex
);

    // beyond this many quiet cycles no key pulse can still be pending
    localparam int QUIET = `SLM_KEY_DELAY_CYCLES + 3;
    localparam panel_pkg::seg_t SEG_OFF = '1;

    int failures = 0;
    int idle_cycles;

    // cycles since key 3 or key 2 was last seen low, saturating
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            idle_cycles <= 0;
        end else if (keys[3:2] != 2'b11) begin
            idle_cycles <= 0;
        end else if (idle_cycles < QUIET) begin
            idle_cycles <= idle_cycles + 1;
        end
    end

    // ==================================================
    // assertions
    // ==================================================
    right_digits_blank: assert property (@(posedge CLOCK_50)
        (hex.hex1 == SEG_OFF) && (hex.hex0 == SEG_OFF))
        else begin
            failures++;
            $error("hex1 or hex0 not blank");
        end

    offsets_hold_when_idle: assert property (@(posedge CLOCK_50) disable iff (delayed_reset)
        (idle_cycles >= QUIET) |-> ($stable(x_offset) && $stable(y_offset)))
        else begin
            failures++;
            $error("offset changed with no key press pending");
        end

    // status field shown whenever an upper switch is on
    leds_follow_status: assert property (@(posedge CLOCK_50) disable iff (delayed_reset)
        (switches[`SLM_SW_W-1:4] != '0) |-> (leds == probe[`SLM_PROBE_W-1:`SLM_SAMPLE_W]))
        else begin
            failures++;
            $error("leds do not follow probe status bits");
        end

endmodule

bind slm_panel_top tb_slm_panel_properties u_props (.*);

/* hdl/front_panel_display.sv */
/*
 * led and seven-segment drivers for the front panel
 * purely combinational, fed by the trace readout and status levels
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module front_panel_display (
    input  trace_pkg::sample_t    slot_data,
    input  trace_pkg::probe_t     probe,
    input  panel_pkg::switches_t  switches,
    input  logic                  write_done,
    output trace_pkg::leds_t      leds,
    output panel_pkg::hex_bank_t  hex
);

    // segment patterns, active low
    localparam panel_pkg::seg_t SEG_B     = 7'b0000011;
    localparam panel_pkg::seg_t SEG_U     = 7'b1000001;
    localparam panel_pkg::seg_t SEG_S     = 7'b0010010;
    localparam panel_pkg::seg_t SEG_Y     = 7'b0010001;
    localparam panel_pkg::seg_t SEG_BLANK = 7'b1111111;

    logic show_slot;

    // only the slot select switches up
    assign show_slot = (switches[`SLM_SW_W-1:4] == '0);

    // ==================================================
    // leds
    // ==================================================
    always_comb begin
        if (show_slot) begin
            leds = {1'b0, slot_data};
        end else begin
            // status field of the probe
            leds = probe[`SLM_PROBE_W-1:`SLM_SAMPLE_W];
        end
    end

    // ==================================================
    // digits
    // ==================================================
    // "busy" until the memory writer finishes
    assign hex.hex5 = write_done ? SEG_BLANK : SEG_B;
    assign hex.hex4 = write_done ? SEG_BLANK : SEG_U;
    assign hex.hex3 = write_done ? SEG_BLANK : SEG_S;
    assign hex.hex2 = write_done ? SEG_BLANK : SEG_Y;
    // right pair unused
    assign hex.hex1 = SEG_BLANK;
    assign hex.hex0 = SEG_BLANK;

endmodule

/* hdl/key_pulse_gen.sv */
/*
 * one active-low key in, one delayed single-cycle pulse out
 * presses that land while a delay is running are dropped
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module key_pulse_gen (
    input  logic CLOCK_50,
    input  logic delayed_reset,
    input  logic key_n,
    output logic pulse
);

    localparam int CNT_W = $clog2(`SLM_KEY_DELAY_CYCLES + 1);

    typedef logic [CNT_W-1:0] count_t;

    // key sample and the sample before it
    logic   key_s;
    logic   key_prev;
    // remaining delay, zero when idle
    count_t count;
    logic   press;

    // falling edge seen while idle
    assign press = !key_s && key_prev && (count == '0);

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            // released key assumed out of reset
            key_s    <= 1'b1;
            key_prev <= 1'b1;
            count    <= '0;
            pulse    <= 1'b0;
        end else begin
            key_s    <= key_n;
            key_prev <= key_s;
            pulse    <= 1'b0;
            if (press) begin
                count <= count_t'(`SLM_KEY_DELAY_CYCLES);
            end else if (count != '0) begin
                count <= count - 1'b1;
                // last tick of the delay fires the pulse
                if (count == count_t'(1)) begin
                    pulse <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/offset_control.sv */
/*
 * x and y image offset registers
 * key 3 loads x, key 2 loads y, value taken from the switches
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module offset_control (
    input  logic                CLOCK_50,
    input  logic                delayed_reset,
    input  panel_pkg::keys_t    keys,
    input  panel_pkg::switches_t switches,
    output panel_pkg::offset_t  x_offset,
    output panel_pkg::offset_t  y_offset
);

    localparam panel_pkg::offset_t X_DEFAULT = '{
        sign: 1'(`SLM_X_DEFAULT_SIGN),
        mag:  panel_pkg::magnitude_t'(`SLM_X_DEFAULT_MAG)
    };
    localparam panel_pkg::offset_t Y_DEFAULT = '{
        sign: 1'(`SLM_Y_DEFAULT_SIGN),
        mag:  panel_pkg::magnitude_t'(`SLM_Y_DEFAULT_MAG)
    };

    logic               load_x;
    logic               load_y;
    panel_pkg::offset_t load_val;

    // ==================================================
    // delayed key pulses
    // ==================================================
    key_pulse_gen u_key_x (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .key_n         (keys[3]),
        .pulse         (load_x)
    );

    key_pulse_gen u_key_y (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .key_n         (keys[2]),
        .pulse         (load_y)
    );

    // sign on sw9, size on sw7..0, sw8 unused here
    assign load_val.sign = switches[9];
    assign load_val.mag  = switches[`SLM_MAG_W-1:0];

    // ==================================================
    // offset registers
    // ==================================================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            x_offset <= X_DEFAULT;
            y_offset <= Y_DEFAULT;
        end else begin
            // independent loads, both may fire together
            if (load_x) begin
                x_offset <= load_val;
            end
            if (load_y) begin
                y_offset <= load_val;
            end
        end
    end

endmodule

/* hdl/panel_pkg.sv */
/*
 * types for the board controls, the image offsets and the digit outputs
 * referenced by scoped name from the offset and display logic
 */
`include "slm_panel_macros.svh"

package panel_pkg;

    // slide switches and push keys, keys are active low
    typedef logic [`SLM_SW_W-1:0]  switches_t;
    typedef logic [`SLM_KEY_W-1:0] keys_t;

    // offset size in pixels
    typedef logic [`SLM_MAG_W-1:0] magnitude_t;

    // signed image offset
    // sign 1 = negative, +x to the right, +y downwards
    typedef struct packed {
        logic       sign;
        magnitude_t mag;
    } offset_t;

    // one seven-segment digit, active low
    typedef logic [`SLM_SEG_W-1:0] seg_t;

    // all six digits, leftmost first
    typedef struct packed {
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } hex_bank_t;

endpackage

/* hdl/slm_panel_top.sv */
/*
 * front-panel control top level for the light-modulator board
 * offsets, trace capture and panel display on one clock
 */
`timescale 1ns/1ns

module slm_panel_top (
    input  logic                 CLOCK_50,
    input  logic                 delayed_reset,
    input  panel_pkg::keys_t     keys,
    input  panel_pkg::switches_t switches,
    input  trace_pkg::probe_t    probe,
    input  logic                 write_done,
    output panel_pkg::offset_t   x_offset,
    output panel_pkg::offset_t   y_offset,
    output trace_pkg::leds_t     leds,
    output panel_pkg::hex_bank_t hex
);

    trace_pkg::slot_idx_t slot_sel;
    trace_pkg::sample_t   slot_data;

    // low switches pick the slot to show
    assign slot_sel = switches[3:0];

    // ==================================================
    // offset registers, straight to the outputs
    // ==================================================
    offset_control u_offsets (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .keys          (keys),
        .switches      (switches),
        .x_offset      (x_offset),
        .y_offset      (y_offset)
    );

    // ==================================================
    // probe capture and panel
    // ==================================================
    trace_capture u_trace (
        .CLOCK_50      (CLOCK_50),
        .delayed_reset (delayed_reset),
        .probe         (probe),
        .slot_sel      (slot_sel),
        .slot_data     (slot_data)
    );

    front_panel_display u_panel (
        .slot_data  (slot_data),
        .probe      (probe),
        .switches   (switches),
        .write_done (write_done),
        .leds       (leds),
        .hex        (hex)
    );

endmodule

/* hdl/trace_capture.sv */
/*
 * small logic analyzer on the lower probe bits
 * keeps pre-trigger history, latches a window around each strobe
 */
`timescale 1ns/1ns
`include "slm_panel_macros.svh"

module trace_capture (
    input  logic                 CLOCK_50,
    input  logic                 delayed_reset,
    input  trace_pkg::probe_t    probe,
    input  trace_pkg::slot_idx_t slot_sel,
    output trace_pkg::sample_t   slot_data
);

    localparam int CNT_W = $clog2(`SLM_TRACE_POST + 1);

    typedef logic [CNT_W-1:0] post_cnt_t;

    // history, index 0 oldest
    trace_pkg::sample_t history [`SLM_TRACE_PRE];
    // latched window, strobe lands in slot PRE
    trace_pkg::sample_t slots [`SLM_TRACE_SLOTS];
    // post-strobe position, zero when idle
    post_cnt_t          post_cnt;
    trace_pkg::sample_t cur_sample;
    logic               strobe;

    assign cur_sample = probe[`SLM_SAMPLE_W-1:0];
    assign strobe     = probe[`SLM_STROBE_BIT];

    // ==================================================
    // pre-trigger shift register
    // ==================================================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            for (int i = 0; i < `SLM_TRACE_PRE; i++) begin
                history[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SLM_TRACE_PRE - 1; i++) begin
                history[i] <= history[i+1];
            end
            history[`SLM_TRACE_PRE-1] <= cur_sample;
        end
    end

    // ==================================================
    // capture window
    // ==================================================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            post_cnt <= '0;
            for (int i = 0; i < `SLM_TRACE_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else if (strobe) begin
            // freeze history plus the strobe sample itself
            for (int i = 0; i < `SLM_TRACE_PRE; i++) begin
                slots[i] <= history[i];
            end
            slots[`SLM_TRACE_PRE] <= cur_sample;
            // restart even if a window is still open
            post_cnt <= post_cnt_t'(1);
        end else if (post_cnt != '0) begin
            // post samples go to slots PRE+1 .. PRE+POST
            slots[trace_pkg::slot_idx_t'(`SLM_TRACE_PRE + int'(post_cnt))] <= cur_sample;
            if (post_cnt == post_cnt_t'(`SLM_TRACE_POST)) begin
                post_cnt <= '0;
            end else begin
                post_cnt <= post_cnt + 1'b1;
            end
        end
    end

    // readout straight from the chosen slot
    assign slot_data = slots[slot_sel];

endmodule

/* hdl/trace_pkg.sv */
/*
 * types for the probe word and the logic analyzer slots
 * referenced by scoped name from the capture and display logic
 */
`include "slm_panel_macros.svh"

package trace_pkg;

    // full probe word
    // bit 8 is the valid strobe, bits 18..9 carry status
    typedef logic [`SLM_PROBE_W-1:0] probe_t;

    // lower probe bits, one stored slot
    typedef logic [`SLM_SAMPLE_W-1:0] sample_t;

    // slot number, wide enough for the whole window
    typedef logic [$clog2(`SLM_TRACE_SLOTS)-1:0] slot_idx_t;

    // red leds on the board
    typedef logic [`SLM_LED_W-1:0] leds_t;

endpackage

/* include/slm_panel_macros.svh */
/*
 * shared constants for the front-panel control block
 * include in any file that needs a delay, depth, width or offset default
 */
`ifndef SLM_PANEL_MACROS_SVH
`define SLM_PANEL_MACROS_SVH

// ==================================================
// key timing
// ==================================================
// press-to-pulse delay in clocks, board build uses 5_000_000
`define SLM_KEY_DELAY_CYCLES 16

// ==================================================
// logic analyzer window
// ==================================================
`define SLM_TRACE_PRE   10
`define SLM_TRACE_POST  5
`define SLM_TRACE_SLOTS 16

// probe word layout
`define SLM_PROBE_W    19
`define SLM_SAMPLE_W   9
`define SLM_STROBE_BIT 8

// front panel widths
`define SLM_LED_W 10
`define SLM_SW_W  10
`define SLM_KEY_W 4
`define SLM_MAG_W 8
`define SLM_SEG_W 7

// offset reset values, sign 1 means negative
`define SLM_X_DEFAULT_MAG  127
`define SLM_X_DEFAULT_SIGN 1
`define SLM_Y_DEFAULT_MAG  3
`define SLM_Y_DEFAULT_SIGN 0

`endif

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_slm_panel -o tb_slm_panel \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_slm_panel +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "simulator exited with an error status" >> sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no verdict found in sim.log"; exit 1; }
echo "simulation passed"

/* sources.f */
+incdir+include
hdl/trace_pkg.sv
hdl/panel_pkg.sv
hdl/key_pulse_gen.sv
hdl/offset_control.sv
hdl/trace_capture.sv
hdl/front_panel_display.sv
hdl/slm_panel_top.sv
bench/tb_slm_panel_properties.sv
bench/tb_slm_panel.sv
